// ==== common/procPkg.sv ====
package procPkg;

   localparam int dataWidth = 16;

   // 1K words of shared instruction and data storage
   localparam int memDepth = 1024;
   localparam int memAddrBits = 10;

   // Instruction formats with the opcode always in [15:11]
   //   R type holds rs [10:8], rt [7:5] and rd [4:2] and writes rs op rt to rd
   //   ADDI, LD and ST hold rs [10:8], rd [7:5] and imm5 [4:0]
   //   LBI, BEQZ and BNEZ hold rs [10:8] and imm8 [7:0]
   //   J holds an 11-bit word displacement
   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opJ    = 5'b00100,
      opAddi = 5'b01000,
      opBeqz = 5'b01100,
      opBnez = 5'b01101,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opLbi  = 5'b11000,
      opAdd  = 5'b11100,
      opSub  = 5'b11101,
      opAnd  = 5'b11110,
      opXor  = 5'b11111
   } opcodeE;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluXor,
      aluPassB
   } aluOpE;

   typedef enum logic [1:0] {
      brNone,
      brEqz,
      brNez,
      brJump
   } branchKindE;

   typedef logic [2:0] regIdxT;

   typedef struct packed {
      logic                 valid;
      logic [dataWidth-1:0] pc;
      logic [dataWidth-1:0] incPc;
      logic [dataWidth-1:0] instr;
   } fdPayloadT;

   typedef struct packed {
      logic                 valid;
      logic [dataWidth-1:0] incPc;
      aluOpE                aluOp;
      logic [dataWidth-1:0] operandA;
      logic [dataWidth-1:0] operandB;
      logic [dataWidth-1:0] imm;
      logic                 useImm;
      logic                 memRead;
      logic                 memWrite;
      logic                 regWrite;
      regIdxT               destReg;
      regIdxT               srcA;
      regIdxT               srcB;
      branchKindE           branchKind;
      logic                 halt;
      logic                 illegal;
   } dxPayloadT;

   typedef struct packed {
      logic                 valid;
      logic [dataWidth-1:0] aluResult;
      logic [dataWidth-1:0] storeData;
      logic                 memRead;
      logic                 memWrite;
      logic                 regWrite;
      regIdxT               destReg;
      logic                 halt;
      logic                 illegal;
   } xmPayloadT;

   typedef struct packed {
      logic                 valid;
      logic [dataWidth-1:0] wbData;
      logic                 regWrite;
      regIdxT               destReg;
      logic                 halt;
      logic                 illegal;
   } mwPayloadT;

   typedef struct packed {
      logic                 valid;
      logic                 regWrite;
      regIdxT               destReg;
      logic [dataWidth-1:0] data;
      logic                 halt;
   } retireT;

   typedef struct packed {
      logic                 valid;
      logic                 write;
      logic [dataWidth-1:0] addr;
      logic [dataWidth-1:0] wdata;
   } memReqT;

endpackage

// ==== rtl/pipeReg.sv ====
`timescale 1ns/1ps

module pipeReg #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    rstN,
   input  logic    stall,
   input  logic    flush,
   input  payloadT d,
   output payloadT q
);

   // Flush wins over stall so a squashed slot never lingers
   always_ff @(posedge clk) begin
      if (!rstN || flush) begin
         q <= '0;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

// ==== rtl/sharedMem.sv ====
`timescale 1ns/1ps

module sharedMem (
   input  logic                          clk,
   input  procPkg::memReqT               loadReq,
   input  procPkg::memReqT               dataReq,
   input  procPkg::memReqT               fetchReq,
   output logic                          dataGrant,
   output logic                          fetchGrant,
   output logic [procPkg::dataWidth-1:0] rdata
);
   import procPkg::*;

   logic [dataWidth-1:0]   mem [memDepth];
   memReqT                 sel;
   logic [memAddrBits-1:0] wordAddr;

   // Loader first, then the memory stage, fetch gets what is left
   always_comb begin
      dataGrant = dataReq.valid & ~loadReq.valid;
      fetchGrant = fetchReq.valid & ~loadReq.valid & ~dataReq.valid;
      if (loadReq.valid) begin
         sel = loadReq;
      end else if (dataReq.valid) begin
         sel = dataReq;
      end else begin
         sel = fetchReq;
      end
   end

   assign wordAddr = sel.addr[memAddrBits-1:0];

   // Read data is ready in the cycle of the grant
   assign rdata = mem[wordAddr];

   always_ff @(posedge clk) begin
      if (sel.valid && sel.write) begin
         mem[wordAddr] <= sel.wdata;
      end
   end

endmodule

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
   input  procPkg::dxPayloadT dxIn,
   input  procPkg::xmPayloadT xmIn,
   input  procPkg::mwPayloadT mwIn,
   input  procPkg::regIdxT    decodeSrcA,
   input  procPkg::regIdxT    decodeSrcB,
   input  logic               branchTaken,
   input  logic               fetchGrant,
   output logic               stallFront,
   output logic               bubbleDx,
   output logic               flushFront,
   output logic [1:0]         fwdASel,
   output logic [1:0]         fwdBSel
);
   import procPkg::*;

   logic loadUse;

   // The memory stage result is younger, so it takes priority
   function automatic logic [1:0] pickFwd(regIdxT src);
      logic [1:0] sel;
      sel = 2'd0;
      if (xmIn.valid && xmIn.regWrite && !xmIn.memRead && xmIn.destReg == src) begin
         sel = 2'd1;
      end else if (mwIn.valid && mwIn.regWrite && mwIn.destReg == src) begin
         sel = 2'd2;
      end
      return sel;
   endfunction

   // Loaded data only exists after the memory stage
   assign loadUse = dxIn.valid & dxIn.memRead & dxIn.regWrite &
                    (dxIn.destReg == decodeSrcA || dxIn.destReg == decodeSrcB);

   // A fetch that lost arbitration retries with decode held in place
   assign stallFront = loadUse | ~fetchGrant;
   assign bubbleDx = stallFront;
   assign flushFront = branchTaken;

   assign fwdASel = pickFwd(dxIn.srcA);
   assign fwdBSel = pickFwd(dxIn.srcB);

endmodule

// ==== rtl/execute.sv ====
`timescale 1ns/1ps

module execute (
   input  procPkg::dxPayloadT            dxIn,
   input  logic [1:0]                    fwdASel,
   input  logic [1:0]                    fwdBSel,
   input  logic [procPkg::dataWidth-1:0] xmFwd,
   input  logic [procPkg::dataWidth-1:0] mwFwd,
   output procPkg::xmPayloadT            xmOut,
   output logic                          branchTaken,
   output logic [procPkg::dataWidth-1:0] branchTarget
);
   import procPkg::*;

   logic [dataWidth-1:0] opA;
   logic [dataWidth-1:0] regB;
   logic [dataWidth-1:0] aluB;
   logic [dataWidth-1:0] aluResult;
   logic                 condMet;

   // Select 1 takes the memory stage result, 2 the writeback result
   always_comb begin
      case (fwdASel)
         2'd1:    opA = xmFwd;
         2'd2:    opA = mwFwd;
         default: opA = dxIn.operandA;
      endcase
      case (fwdBSel)
         2'd1:    regB = xmFwd;
         2'd2:    regB = mwFwd;
         default: regB = dxIn.operandB;
      endcase
   end

   assign aluB = dxIn.useImm ? dxIn.imm : regB;

   always_comb begin
      case (dxIn.aluOp)
         aluSub:   aluResult = opA - aluB;
         aluAnd:   aluResult = opA & aluB;
         aluXor:   aluResult = opA ^ aluB;
         aluPassB: aluResult = aluB;
         default:  aluResult = opA + aluB;
      endcase
   end

   always_comb begin
      case (dxIn.branchKind)
         brEqz:   condMet = (opA == '0);
         brNez:   condMet = (opA != '0);
         brJump:  condMet = 1'b1;
         default: condMet = 1'b0;
      endcase
   end

   assign branchTaken = dxIn.valid & condMet;
   assign branchTarget = dxIn.incPc + dxIn.imm;

   always_comb begin
      xmOut.valid = dxIn.valid;
      xmOut.aluResult = aluResult;
      xmOut.storeData = regB;
      xmOut.memRead = dxIn.memRead;
      xmOut.memWrite = dxIn.memWrite;
      xmOut.regWrite = dxIn.regWrite;
      xmOut.destReg = dxIn.destReg;
      xmOut.halt = dxIn.halt;
      xmOut.illegal = dxIn.illegal;
   end

endmodule

// ==== rtl/decode/regFile.sv ====
`timescale 1ns/1ps

module regFile (
   input  logic                          clk,
   input  logic                          rstN,
   input  procPkg::regIdxT               rdA,
   input  procPkg::regIdxT               rdB,
   input  logic                          wrEn,
   input  procPkg::regIdxT               wrIdx,
   input  logic [procPkg::dataWidth-1:0] wrData,
   output logic [procPkg::dataWidth-1:0] dataA,
   output logic [procPkg::dataWidth-1:0] dataB
);
   import procPkg::*;

   logic [dataWidth-1:0] regs [8];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrIdx] <= wrData;
      end
   end

   // Writeback in the same cycle is seen by decode right away
   assign dataA = (wrEn && wrIdx == rdA) ? wrData : regs[rdA];
   assign dataB = (wrEn && wrIdx == rdB) ? wrData : regs[rdB];

endmodule

// ==== rtl/decode/decode.sv ====
`timescale 1ns/1ps

module decode (
   input  logic               clk,
   input  logic               rstN,
   input  procPkg::fdPayloadT fdIn,
   input  procPkg::mwPayloadT wbIn,
   output procPkg::dxPayloadT dxOut
);
   import procPkg::*;

   opcodeE               op;
   regIdxT               rs;
   regIdxT               rt;
   regIdxT               rd;
   logic [dataWidth-1:0] imm5;
   logic [dataWidth-1:0] imm8;
   logic [dataWidth-1:0] imm11;
   logic [dataWidth-1:0] dataA;
   logic [dataWidth-1:0] dataB;

   assign op = opcodeE'(fdIn.instr[15:11]);
   assign rs = fdIn.instr[10:8];
   assign rt = fdIn.instr[7:5];
   assign rd = fdIn.instr[4:2];

   assign imm5 = {{(dataWidth-5){fdIn.instr[4]}}, fdIn.instr[4:0]};
   assign imm8 = {{(dataWidth-8){fdIn.instr[7]}}, fdIn.instr[7:0]};
   assign imm11 = {{(dataWidth-11){fdIn.instr[10]}}, fdIn.instr[10:0]};

   regFile u_regFile (
      .clk   (clk),
      .rstN  (rstN),
      .rdA   (rs),
      .rdB   (rt),
      .wrEn  (wbIn.valid & wbIn.regWrite),
      .wrIdx (wbIn.destReg),
      .wrData(wbIn.wbData),
      .dataA (dataA),
      .dataB (dataB)
   );

   always_comb begin
      dxOut.valid = fdIn.valid;
      dxOut.incPc = fdIn.incPc;
      dxOut.aluOp = aluAdd;
      dxOut.operandA = dataA;
      dxOut.operandB = dataB;
      dxOut.imm = '0;
      dxOut.useImm = 1'b0;
      dxOut.memRead = 1'b0;
      dxOut.memWrite = 1'b0;
      dxOut.regWrite = 1'b0;
      dxOut.destReg = rd;
      dxOut.srcA = rs;
      dxOut.srcB = rt;
      dxOut.branchKind = brNone;
      dxOut.halt = 1'b0;
      dxOut.illegal = 1'b0;

      case (op)
         opAdd: dxOut.regWrite = 1'b1;
         opSub: begin
            dxOut.aluOp = aluSub;
            dxOut.regWrite = 1'b1;
         end
         opAnd: begin
            dxOut.aluOp = aluAnd;
            dxOut.regWrite = 1'b1;
         end
         opXor: begin
            dxOut.aluOp = aluXor;
            dxOut.regWrite = 1'b1;
         end
         opAddi, opLd: begin
            dxOut.imm = imm5;
            dxOut.useImm = 1'b1;
            dxOut.memRead = (op == opLd);
            dxOut.regWrite = 1'b1;
            dxOut.destReg = rt;
         end
         // Address is rs + imm5 and the stored value comes from the rt slot
         opSt: begin
            dxOut.imm = imm5;
            dxOut.useImm = 1'b1;
            dxOut.memWrite = 1'b1;
         end
         opLbi: begin
            dxOut.aluOp = aluPassB;
            dxOut.imm = imm8;
            dxOut.useImm = 1'b1;
            dxOut.regWrite = 1'b1;
            dxOut.destReg = rs;
         end
         opBeqz: begin
            dxOut.imm = imm8;
            dxOut.branchKind = brEqz;
         end
         opBnez: begin
            dxOut.imm = imm8;
            dxOut.branchKind = brNez;
         end
         opJ: begin
            dxOut.imm = imm11;
            dxOut.branchKind = brJump;
         end
         opHalt: dxOut.halt = 1'b1;
         // Unknown opcodes leave every write enable low
         default: dxOut.illegal = 1'b1;
      endcase
   end

endmodule

// ==== rtl/fetch/fetch.sv ====
`timescale 1ns/1ps

module fetch (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          stall,
   input  logic                          redirect,
   input  logic [procPkg::dataWidth-1:0] target,
   input  logic                          grant,
   input  logic [procPkg::dataWidth-1:0] rdata,
   input  logic                          halted,
   output procPkg::memReqT               memReq,
   output procPkg::fdPayloadT            fdOut
);
   import procPkg::*;

   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] incPc;

   assign incPc = pc + 1'b1;

   // Read the current word every cycle until the machine halts
   always_comb begin
      memReq.valid = ~halted;
      memReq.write = 1'b0;
      memReq.addr = pc;
      memReq.wdata = '0;
   end

   // The word is only a real instruction when the arbiter granted us
   always_comb begin
      fdOut.valid = grant;
      fdOut.pc = pc;
      fdOut.incPc = incPc;
      fdOut.instr = rdata;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= target;
      end else if (grant && !stall) begin
         pc <= incPc;
      end
   end

endmodule

// ==== rtl/proc.sv ====
`timescale 1ns/1ps

module proc (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          loadEn,
   input  logic [procPkg::dataWidth-1:0] loadAddr,
   input  logic [procPkg::dataWidth-1:0] loadData,
   output procPkg::retireT               retire,
   output logic                          halted,
   output logic                          err
);
   import procPkg::*;

   memReqT               fetchReq;
   memReqT               dataReq;
   memReqT               loadReq;
   fdPayloadT            fdD;
   fdPayloadT            fdQ;
   dxPayloadT            dxD;
   dxPayloadT            dxQ;
   xmPayloadT            xmD;
   xmPayloadT            xmQ;
   mwPayloadT            mwD;
   mwPayloadT            mwQ;
   logic                 fetchGrant;
   logic                 dataGrant;
   logic [dataWidth-1:0] memRdata;
   logic                 branchTaken;
   logic [dataWidth-1:0] branchTarget;
   logic                 stallFront;
   logic                 bubbleDx;
   logic                 flushFront;
   logic [1:0]           fwdASel;
   logic [1:0]           fwdBSel;
   logic                 dataMiss;
   logic                 frontFlush;
   logic                 haltNow;
   logic                 drain;

   // A data access that loses to the loader freezes everything up to memory
   assign dataMiss = dataReq.valid & ~dataGrant;
   assign frontFlush = flushFront & ~dataMiss;

   // Younger work behind a retiring HALT is squashed
   assign haltNow = mwQ.valid & mwQ.halt;
   assign drain = halted | haltNow;

   assign loadReq = '{valid: loadEn, write: 1'b1, addr: loadAddr, wdata: loadData};

   fetch u_fetch (
      .clk     (clk),
      .rstN    (rstN),
      .stall   (stallFront | dataMiss),
      .redirect(frontFlush),
      .target  (branchTarget),
      .grant   (fetchGrant),
      .rdata   (memRdata),
      .halted  (halted),
      .memReq  (fetchReq),
      .fdOut   (fdD)
   );

   pipeReg #(.payloadT(fdPayloadT)) fdReg (
      .clk  (clk),
      .rstN (rstN),
      .stall(stallFront | dataMiss),
      .flush(frontFlush | drain),
      .d    (fdD),
      .q    (fdQ)
   );

   decode u_decode (
      .clk  (clk),
      .rstN (rstN),
      .fdIn (fdQ),
      .wbIn (mwQ),
      .dxOut(dxD)
   );

   pipeReg #(.payloadT(dxPayloadT)) dxReg (
      .clk  (clk),
      .rstN (rstN),
      .stall(dataMiss),
      .flush(((bubbleDx | flushFront) & ~dataMiss) | drain),
      .d    (dxD),
      .q    (dxQ)
   );

   execute u_execute (
      .dxIn        (dxQ),
      .fwdASel     (fwdASel),
      .fwdBSel     (fwdBSel),
      .xmFwd       (xmQ.aluResult),
      .mwFwd       (mwQ.wbData),
      .xmOut       (xmD),
      .branchTaken (branchTaken),
      .branchTarget(branchTarget)
   );

   pipeReg #(.payloadT(xmPayloadT)) xmReg (
      .clk  (clk),
      .rstN (rstN),
      .stall(dataMiss),
      .flush(drain),
      .d    (xmD),
      .q    (xmQ)
   );

   // Memory stage
   always_comb begin
      dataReq.valid = xmQ.valid & (xmQ.memRead | xmQ.memWrite) & ~drain;
      dataReq.write = xmQ.memWrite;
      dataReq.addr = xmQ.aluResult;
      dataReq.wdata = xmQ.storeData;

      mwD.valid = xmQ.valid;
      mwD.wbData = xmQ.memRead ? memRdata : xmQ.aluResult;
      mwD.regWrite = xmQ.regWrite;
      mwD.destReg = xmQ.destReg;
      mwD.halt = xmQ.halt;
      mwD.illegal = xmQ.illegal;
   end

   sharedMem u_sharedMem (
      .clk       (clk),
      .loadReq   (loadReq),
      .dataReq   (dataReq),
      .fetchReq  (fetchReq),
      .dataGrant (dataGrant),
      .fetchGrant(fetchGrant),
      .rdata     (memRdata)
   );

   pipeReg #(.payloadT(mwPayloadT)) mwReg (
      .clk  (clk),
      .rstN (rstN),
      .stall(1'b0),
      .flush(drain | dataMiss),
      .d    (mwD),
      .q    (mwQ)
   );

   hazardUnit u_hazardUnit (
      .dxIn       (dxQ),
      .xmIn       (xmQ),
      .mwIn       (mwQ),
      .decodeSrcA (dxD.srcA),
      .decodeSrcB (dxD.srcB),
      .branchTaken(branchTaken),
      .fetchGrant (fetchGrant),
      .stallFront (stallFront),
      .bubbleDx   (bubbleDx),
      .flushFront (flushFront),
      .fwdASel    (fwdASel),
      .fwdBSel    (fwdBSel)
   );

   // Writeback
   always_comb begin
      retire.valid = mwQ.valid;
      retire.regWrite = mwQ.valid & mwQ.regWrite;
      retire.destReg = mwQ.destReg;
      retire.data = mwQ.wbData;
      retire.halt = haltNow;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         halted <= 1'b0;
         err <= 1'b0;
      end else begin
         if (haltNow) begin
            halted <= 1'b1;
         end
         if (mwQ.valid && mwQ.illegal) begin
            err <= 1'b1;
         end
      end
   end

endmodule

// ==== dv/procChecker.sv ====
`timescale 1ns/1ps

module procChecker (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          loadEn,
   input  logic [procPkg::dataWidth-1:0] loadAddr,
   input  logic [procPkg::dataWidth-1:0] loadData,
   input  procPkg::retireT               retire,
   input  logic                          halted,
   input  logic                          err,
   input  int                            expRetires,
   input  logic                          endTest,
   output int                            valueErrs,
   output int                            otherErrs
);
   import procPkg::*;

   logic [dataWidth-1:0] modelMem [memDepth];
   retireT               expQ [$];
   logic                 modelErr;
   logic                 prevRstN;
   int                   seen;

   initial begin
      valueErrs = 0;
      otherErrs = 0;
      prevRstN = 1'b0;
      seen = 0;
      modelErr = 1'b0;
   end

   // Instruction-level model that runs the whole program once reset is released
   task automatic runModel();
      logic [dataWidth-1:0] regs [8];
      logic [dataWidth-1:0] pc;
      logic [dataWidth-1:0] nextPc;
      logic [dataWidth-1:0] instr;
      logic [dataWidth-1:0] i5;
      logic [dataWidth-1:0] i8;
      logic [dataWidth-1:0] i11;
      logic [dataWidth-1:0] addr;
      logic [4:0]           op;
      regIdxT               rs;
      regIdxT               rt;
      regIdxT               rd;
      retireT               e;
      logic                 done;
      expQ.delete();
      modelErr = 1'b0;
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      pc = '0;
      done = 1'b0;
      for (int step = 0; step < 256 && !done; step++) begin
         instr = modelMem[pc[memAddrBits-1:0]];
         op = instr[15:11];
         rs = instr[10:8];
         rt = instr[7:5];
         rd = instr[4:2];
         i5 = {{11{instr[4]}}, instr[4:0]};
         i8 = {{8{instr[7]}}, instr[7:0]};
         i11 = {{5{instr[10]}}, instr[10:0]};
         addr = regs[rs] + i5;
         nextPc = pc + 16'd1;
         e = '0;
         e.valid = 1'b1;
         case (op)
            opAdd, opSub, opAnd, opXor: begin
               if (op == opAdd) e.data = regs[rs] + regs[rt];
               else if (op == opSub) e.data = regs[rs] - regs[rt];
               else if (op == opAnd) e.data = regs[rs] & regs[rt];
               else e.data = regs[rs] ^ regs[rt];
               e.regWrite = 1'b1;
               e.destReg = rd;
            end
            opAddi, opLd: begin
               e.data = (op == opLd) ? modelMem[addr[memAddrBits-1:0]] : addr;
               e.regWrite = 1'b1;
               e.destReg = rt;
            end
            opSt: modelMem[addr[memAddrBits-1:0]] = regs[rt];
            opLbi: begin
               e.data = i8;
               e.regWrite = 1'b1;
               e.destReg = rs;
            end
            opBeqz: if (regs[rs] == '0) nextPc = pc + 16'd1 + i8;
            opBnez: if (regs[rs] != '0) nextPc = pc + 16'd1 + i8;
            opJ: nextPc = pc + 16'd1 + i11;
            opHalt: begin
               e.halt = 1'b1;
               done = 1'b1;
            end
            default: modelErr = 1'b1;
         endcase
         if (e.regWrite) begin
            regs[e.destReg] = e.data;
         end
         expQ.push_back(e);
         pc = nextPc;
      end
   endtask

   task automatic checkRetire();
      retireT e;
      seen++;
      if (halted) begin
         $display("Error at time %0t: an instruction retired after HALT", $time);
         otherErrs++;
      end else if (expQ.size() == 0) begin
         $display("Error at time %0t: a retire came with nothing left in the model", $time);
         otherErrs++;
      end else begin
         e = expQ.pop_front();
         if (retire.regWrite != e.regWrite || retire.halt != e.halt) begin
            $display("Fail at time %0t: retire kind regWrite %b halt %b, expected %b %b",
                     $time, retire.regWrite, retire.halt, e.regWrite, e.halt);
            valueErrs++;
         end else if (e.regWrite &&
                      (retire.destReg != e.destReg || retire.data != e.data)) begin
            $display("Fail at time %0t: r%0d = %h retired, expected r%0d = %h",
                     $time, retire.destReg, retire.data, e.destReg, e.data);
            valueErrs++;
         end
      end
   endtask

   task automatic checkEnd();
      if (!halted) begin
         $display("Error at time %0t: the program ended without halting", $time);
         otherErrs++;
      end
      if (seen != expRetires) begin
         $display("Error at time %0t: %0d instructions retired where %0d were expected",
                  $time, seen, expRetires);
         otherErrs++;
      end
      if (expQ.size() != 0) begin
         $display("Error at time %0t: %0d model instructions never retired",
                  $time, expQ.size());
         otherErrs++;
      end
      if (err != modelErr) begin
         $display("Fail at time %0t: err is %b, expected %b", $time, err, modelErr);
         valueErrs++;
      end
   endtask

   // Sample on the falling edge when every DUT output has settled
   always @(negedge clk) begin
      if (loadEn) begin
         modelMem[loadAddr[memAddrBits-1:0]] = loadData;
      end
      if (rstN && !prevRstN) begin
         runModel();
         seen = 0;
      end else if (rstN) begin
         if (retire.valid) begin
            checkRetire();
         end
         if (endTest) begin
            checkEnd();
         end
      end
      prevRstN = rstN;
   end

endmodule

// ==== dv/procTb.sv ====
`timescale 1ns/1ps

module procTb;
   import procPkg::*;

   localparam int numTests = 5;
   localparam int progWords = 16;
   localparam int loadWords = 32;
   localparam int cyclesPerTest = 200;

   logic                 clk;
   logic                 rstN;
   logic                 loadEn;
   logic [dataWidth-1:0] loadAddr;
   logic [dataWidth-1:0] loadData;
   retireT               retire;
   logic                 halted;
   logic                 err;
   int                   expRetires;
   logic                 endTest;
   int                   valueErrs;
   int                   otherErrs;

   logic [15:0] progTable [numTests][progWords];
   int          progLen [numTests];
   int          retireTable [numTests];
   logic [31:0] lfsrState;

   proc i_proc (
      .clk     (clk),
      .rstN    (rstN),
      .loadEn  (loadEn),
      .loadAddr(loadAddr),
      .loadData(loadData),
      .retire  (retire),
      .halted  (halted),
      .err     (err)
   );

   procChecker u_checker (
      .clk       (clk),
      .rstN      (rstN),
      .loadEn    (loadEn),
      .loadAddr  (loadAddr),
      .loadData  (loadData),
      .retire    (retire),
      .halted    (halted),
      .err       (err),
      .expRetires(expRetires),
      .endTest   (endTest),
      .valueErrs (valueErrs),
      .otherErrs (otherErrs)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   function automatic logic [15:0] rType(opcodeE op, regIdxT rs, regIdxT rt, regIdxT rd);
      return {op, rs, rt, rd, 2'b00};
   endfunction

   function automatic logic [15:0] iType(opcodeE op, regIdxT rs, regIdxT rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] bType(opcodeE op, regIdxT rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   // Fibonacci LFSR with taps 32, 22, 2 and 1 stepped once per bit
   function automatic logic [15:0] takeBits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsrState = {lfsrState[30:0],
                      lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
         v = {v[14:0], lfsrState[0]};
      end
      return v;
   endfunction

   task automatic buildTable();
      // ALU ops, ADDI and LBI
      progTable[0][0] = bType(opLbi, 3'd1, 8'd0);
      progTable[0][1] = bType(opLbi, 3'd2, 8'd0);
      progTable[0][2] = iType(opAddi, 3'd1, 3'd3, 5'd7);
      progTable[0][3] = rType(opAdd, 3'd1, 3'd2, 3'd4);
      progTable[0][4] = rType(opSub, 3'd1, 3'd2, 3'd5);
      progTable[0][5] = rType(opAnd, 3'd1, 3'd2, 3'd6);
      progTable[0][6] = rType(opXor, 3'd1, 3'd2, 3'd7);
      progTable[0][7] = iType(opAddi, 3'd3, 3'd3, 5'h1d);
      progTable[0][8] = 16'h0000;
      progLen[0] = 9;
      retireTable[0] = 9;
      // Dependent chain through forwarding
      progTable[1][0] = bType(opLbi, 3'd1, 8'd0);
      progTable[1][1] = iType(opAddi, 3'd1, 3'd2, 5'd1);
      progTable[1][2] = rType(opAdd, 3'd2, 3'd1, 3'd3);
      progTable[1][3] = rType(opSub, 3'd3, 3'd2, 3'd4);
      progTable[1][4] = rType(opXor, 3'd4, 3'd3, 3'd5);
      progTable[1][5] = rType(opAnd, 3'd5, 3'd4, 3'd6);
      progTable[1][6] = rType(opAdd, 3'd6, 3'd5, 3'd6);
      progTable[1][7] = iType(opAddi, 3'd6, 3'd6, 5'h1f);
      progTable[1][8] = 16'h0000;
      progLen[1] = 9;
      retireTable[1] = 9;
      // Loads used right away and a store then load on data at words 16 and up
      progTable[2][0] = iType(opAddi, 3'd0, 3'd1, 5'd15);
      progTable[2][1] = iType(opLd, 3'd1, 3'd2, 5'd1);
      progTable[2][2] = rType(opAdd, 3'd2, 3'd2, 3'd3);
      progTable[2][3] = iType(opSt, 3'd1, 3'd3, 5'd2);
      progTable[2][4] = iType(opLd, 3'd1, 3'd4, 5'd2);
      progTable[2][5] = iType(opAddi, 3'd4, 3'd5, 5'd1);
      progTable[2][6] = iType(opLd, 3'd1, 3'd6, 5'd3);
      progTable[2][7] = iType(opSt, 3'd1, 3'd6, 5'd4);
      progTable[2][8] = iType(opLd, 3'd1, 3'd7, 5'd4);
      progTable[2][9] = 16'h0000;
      progLen[2] = 10;
      retireTable[2] = 10;
      // Branches taken and not taken with r2 zero and r3 five
      progTable[3][0] = bType(opLbi, 3'd1, 8'd0);
      progTable[3][1] = rType(opXor, 3'd1, 3'd1, 3'd2);
      progTable[3][2] = iType(opAddi, 3'd2, 3'd3, 5'd5);
      progTable[3][3] = bType(opBeqz, 3'd3, 8'd2);
      progTable[3][4] = bType(opBeqz, 3'd2, 8'd2);
      progTable[3][5] = iType(opAddi, 3'd0, 3'd4, 5'd1);
      progTable[3][6] = iType(opAddi, 3'd0, 3'd4, 5'd2);
      progTable[3][7] = bType(opBnez, 3'd2, 8'd1);
      progTable[3][8] = bType(opBnez, 3'd3, 8'd1);
      progTable[3][9] = iType(opAddi, 3'd0, 3'd5, 5'd3);
      progTable[3][10] = {opJ, 11'd1};
      progTable[3][11] = iType(opAddi, 3'd0, 3'd6, 5'd4);
      progTable[3][12] = iType(opAddi, 3'd3, 3'd7, 5'd1);
      progTable[3][13] = 16'h0000;
      progLen[3] = 14;
      retireTable[3] = 10;
      // Illegal opcode and then HALT with one instruction behind it
      progTable[4][0] = bType(opLbi, 3'd1, 8'd0);
      progTable[4][1] = {5'b00001, 11'h0e5};
      progTable[4][2] = iType(opAddi, 3'd1, 3'd2, 5'd2);
      progTable[4][3] = 16'h0000;
      progTable[4][4] = iType(opAddi, 3'd0, 3'd3, 5'd1);
      progLen[4] = 5;
      retireTable[4] = 4;
   endtask

   // LBI immediates and all words past the program come from the LFSR
   task automatic loadProgram(input int t);
      logic [15:0] w;
      logic [15:0] r;
      for (int a = 0; a < loadWords; a++) begin
         if (a < progLen[t]) begin
            w = progTable[t][a];
            if (w[15:11] == opLbi) begin
               r = takeBits(8);
               w[7:0] = r[7:0];
            end
         end else begin
            w = takeBits(16);
         end
         @(posedge clk);
         loadEn <= 1'b1;
         loadAddr <= 16'(a);
         loadData <= w;
      end
      @(posedge clk);
      loadEn <= 1'b0;
   endtask

   initial begin
      rstN = 1'b0;
      loadEn = 1'b0;
      loadAddr = '0;
      loadData = '0;
      endTest = 1'b0;
      expRetires = 0;
      lfsrState = 32'he255fb7e;
      buildTable();
      for (int t = 0; t < numTests; t++) begin
         @(posedge clk);
         rstN <= 1'b0;
         expRetires <= retireTable[t];
         loadProgram(t);
         repeat (3) @(posedge clk);
         rstN <= 1'b1;
         while (!halted) @(negedge clk);
         // A few idle cycles show that nothing retires after HALT
         repeat (4) @(posedge clk);
         endTest <= 1'b1;
         @(posedge clk);
         endTest <= 1'b0;
      end
      @(negedge clk);
      $display("Errors: %0d value, %0d other", valueErrs, otherErrs);
      if (valueErrs == 0 && otherErrs == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      repeat (numTests * cyclesPerTest) @(posedge clk);
      $display("Timeout: the programs did not all halt in time");
      $display("sim failed");
      $finish;
   end

endmodule

// ==== list.f ====
common/procPkg.sv
rtl/pipeReg.sv
rtl/sharedMem.sv
rtl/hazardUnit.sv
rtl/execute.sv
rtl/decode/regFile.sv
rtl/decode/decode.sv
rtl/fetch/fetch.sv
rtl/proc.sv
dv/procChecker.sv
dv/procTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module procTb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/VprocTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
   exit 0
fi
exit 1
